//--- video_timing_pkg.sv
package video_timing_pkg;

    localparam int H_COUNT_W = 12;
    localparam int V_COUNT_W = 11;

    typedef logic [H_COUNT_W-1:0] h_count_t;
    typedef logic [V_COUNT_W-1:0] v_count_t;

    // 1920x1080, totals 2200 x 1125.
    localparam h_count_t H_ACTIVE_1080P = 12'd1920;
    localparam h_count_t H_FRONT_1080P  = 12'd88;
    localparam h_count_t H_SYNC_1080P   = 12'd44;
    localparam h_count_t H_BACK_1080P   = 12'd148;
    localparam v_count_t V_ACTIVE_1080P = 11'd1080;
    localparam v_count_t V_FRONT_1080P  = 11'd4;
    localparam v_count_t V_SYNC_1080P   = 11'd5;
    localparam v_count_t V_BACK_1080P   = 11'd36;

    // 1280x960, totals 1800 x 1000.
    localparam h_count_t H_ACTIVE_960P  = 12'd1280;
    localparam h_count_t H_FRONT_960P   = 12'd96;
    localparam h_count_t H_SYNC_960P    = 12'd112;
    localparam h_count_t H_BACK_960P    = 12'd312;
    localparam v_count_t V_ACTIVE_960P  = 11'd960;
    localparam v_count_t V_FRONT_960P   = 11'd1;
    localparam v_count_t V_SYNC_960P    = 11'd3;
    localparam v_count_t V_BACK_960P    = 11'd36;

    // 720x480, totals 858 x 525.
    localparam h_count_t H_ACTIVE_480P  = 12'd720;
    localparam h_count_t H_FRONT_480P   = 12'd16;
    localparam h_count_t H_SYNC_480P    = 12'd62;
    localparam h_count_t H_BACK_480P    = 12'd60;
    localparam v_count_t V_ACTIVE_480P  = 11'd480;
    localparam v_count_t V_FRONT_480P   = 11'd9;
    localparam v_count_t V_SYNC_480P    = 11'd6;
    localparam v_count_t V_BACK_480P    = 11'd30;

    // 640x480, totals 800 x 525.
    localparam h_count_t H_ACTIVE_VGA   = 12'd640;
    localparam h_count_t H_FRONT_VGA    = 12'd16;
    localparam h_count_t H_SYNC_VGA     = 12'd96;
    localparam h_count_t H_BACK_VGA     = 12'd48;
    localparam v_count_t V_ACTIVE_VGA   = 11'd480;
    localparam v_count_t V_FRONT_VGA    = 11'd10;
    localparam v_count_t V_SYNC_VGA     = 11'd2;
    localparam v_count_t V_BACK_VGA     = 11'd33;

    // 720x576, totals 864 x 625.
    localparam h_count_t H_ACTIVE_576P  = 12'd720;
    localparam h_count_t H_FRONT_576P   = 12'd12;
    localparam h_count_t H_SYNC_576P    = 12'd64;
    localparam h_count_t H_BACK_576P    = 12'd68;
    localparam v_count_t V_ACTIVE_576P  = 11'd576;
    localparam v_count_t V_FRONT_576P   = 11'd5;
    localparam v_count_t V_SYNC_576P    = 11'd5;
    localparam v_count_t V_BACK_576P    = 11'd39;

    // 240p keeps the line timing of its output mode, 262 lines per frame.
    localparam v_count_t V_ACTIVE_240P  = 11'd240;
    localparam v_count_t V_FRONT_240P   = 11'd4;
    localparam v_count_t V_SYNC_240P    = 11'd3;
    localparam v_count_t V_BACK_240P    = 11'd15;

    // Interlaced modes count one field per frame.
    localparam h_count_t H_ACTIVE_480I  = 12'd720;
    localparam h_count_t H_FRONT_480I   = 12'd19;
    localparam h_count_t H_SYNC_480I    = 12'd62;
    localparam h_count_t H_BACK_480I    = 12'd57;
    localparam v_count_t V_ACTIVE_480I  = 11'd240;
    localparam v_count_t V_FRONT_480I   = 11'd4;
    localparam v_count_t V_SYNC_480I    = 11'd3;
    localparam v_count_t V_BACK_480I    = 11'd15;

    localparam h_count_t H_ACTIVE_576I  = 12'd720;
    localparam h_count_t H_FRONT_576I   = 12'd12;
    localparam h_count_t H_SYNC_576I    = 12'd63;
    localparam h_count_t H_BACK_576I    = 12'd69;
    localparam v_count_t V_ACTIVE_576I  = 11'd288;
    localparam v_count_t V_FRONT_576I   = 11'd2;
    localparam v_count_t V_SYNC_576I    = 11'd3;
    localparam v_count_t V_BACK_576I    = 11'd19;

endpackage

//--- video_mode_pkg.sv
package video_mode_pkg;

    typedef logic [7:0] ctrl_byte_t;
    typedef logic [6:0] mode_code_t;

    typedef enum logic [3:0] {
        MODE_1080P,
        MODE_960P,
        MODE_480P,
        MODE_VGA,
        MODE_576P,
        MODE_240P_1080P,
        MODE_240P_960P,
        MODE_240P_480P,
        MODE_240P_VGA,
        MODE_480I,
        MODE_576I
    } video_mode_t;

    localparam video_mode_t MODE_RESET = MODE_1080P;

    localparam mode_code_t CODE_1080P      = 7'h00;
    localparam mode_code_t CODE_960P       = 7'h01;
    localparam mode_code_t CODE_480P       = 7'h02;
    localparam mode_code_t CODE_VGA        = 7'h03;
    localparam mode_code_t CODE_576P       = 7'h08;
    localparam mode_code_t CODE_240P_1080P = 7'h10;
    localparam mode_code_t CODE_240P_960P  = 7'h11;
    localparam mode_code_t CODE_240P_480P  = 7'h12;
    localparam mode_code_t CODE_240P_VGA   = 7'h13;
    localparam mode_code_t CODE_480I       = 7'h20;
    localparam mode_code_t CODE_576I       = 7'h40;
    localparam mode_code_t CODE_ALIAS_SPAN = 7'd3;  // 576p, 480i and 576i take four codes each.

endpackage

//--- video_mode_select.sv
`timescale 1ns/1ps

module video_mode_select
    import video_mode_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  ctrl_byte_t  ctrl,
    output video_mode_t mode,
    output logic        native_hd
);

    ctrl_byte_t  ctrl_q;        // Byte seen on the previous edge.
    mode_code_t  code;
    video_mode_t dec_mode;
    video_mode_t mode_stage;
    logic        native_stage;

    assign code = ctrl[6:0];    // Bit 7 carries no mode information.

    always_comb begin
        dec_mode = mode_stage;  // Unknown codes keep the current selection.
        case (code) inside
            CODE_1080P:      dec_mode = MODE_1080P;
            CODE_960P:       dec_mode = MODE_960P;
            CODE_480P:       dec_mode = MODE_480P;
            CODE_VGA:        dec_mode = MODE_VGA;
            CODE_240P_1080P: dec_mode = MODE_240P_1080P;
            CODE_240P_960P:  dec_mode = MODE_240P_960P;
            CODE_240P_480P:  dec_mode = MODE_240P_480P;
            CODE_240P_VGA:   dec_mode = MODE_240P_VGA;
            [CODE_576P : CODE_576P + CODE_ALIAS_SPAN]: dec_mode = MODE_576P;
            [CODE_480I : CODE_480I + CODE_ALIAS_SPAN]: dec_mode = MODE_480I;
            [CODE_576I : CODE_576I + CODE_ALIAS_SPAN]: dec_mode = MODE_576I;
            default:         dec_mode = mode_stage;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            ctrl_q       <= '0;
            mode_stage   <= MODE_RESET;
            native_stage <= 1'b1;
            mode         <= MODE_RESET;
            native_hd    <= 1'b1;
        end else begin
            ctrl_q <= ctrl;
            if (ctrl != ctrl_q) begin   // Decode only on a new byte.
                mode_stage   <= dec_mode;
                native_stage <= (dec_mode == MODE_1080P) || (dec_mode == MODE_960P);
            end
            mode      <= mode_stage;    // Second stage, one cycle after decode.
            native_hd <= native_stage;
        end
    end

endmodule

//--- video_mode_table.sv
`timescale 1ns/1ps

module video_mode_table
    import video_mode_pkg::*;
    import video_timing_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  video_mode_t mode,
    output h_count_t    h_active,
    output h_count_t    h_front,
    output h_count_t    h_sync,
    output h_count_t    h_back,
    output v_count_t    v_active,
    output v_count_t    v_front,
    output v_count_t    v_sync,
    output v_count_t    v_back,
    output logic        interlaced
);

    video_mode_t                   lookup_mode;
    logic [4*$bits(h_count_t)-1:0] h_timing_n;
    logic [4*$bits(v_count_t)-1:0] v_timing_n;

    assign lookup_mode = rst_n ? mode : MODE_RESET;    // Reset loads the 1080p timing.

    always_comb begin
        case (lookup_mode)
            MODE_960P, MODE_240P_960P:
                h_timing_n = {H_ACTIVE_960P, H_FRONT_960P, H_SYNC_960P, H_BACK_960P};
            MODE_480P, MODE_240P_480P:
                h_timing_n = {H_ACTIVE_480P, H_FRONT_480P, H_SYNC_480P, H_BACK_480P};
            MODE_VGA, MODE_240P_VGA:
                h_timing_n = {H_ACTIVE_VGA, H_FRONT_VGA, H_SYNC_VGA, H_BACK_VGA};
            MODE_576P:
                h_timing_n = {H_ACTIVE_576P, H_FRONT_576P, H_SYNC_576P, H_BACK_576P};
            MODE_480I:
                h_timing_n = {H_ACTIVE_480I, H_FRONT_480I, H_SYNC_480I, H_BACK_480I};
            MODE_576I:
                h_timing_n = {H_ACTIVE_576I, H_FRONT_576I, H_SYNC_576I, H_BACK_576I};
            default:    // 1080p line, shared with 240p on 1080p.
                h_timing_n = {H_ACTIVE_1080P, H_FRONT_1080P, H_SYNC_1080P, H_BACK_1080P};
        endcase

        case (lookup_mode)
            MODE_960P:
                v_timing_n = {V_ACTIVE_960P, V_FRONT_960P, V_SYNC_960P, V_BACK_960P};
            MODE_480P:
                v_timing_n = {V_ACTIVE_480P, V_FRONT_480P, V_SYNC_480P, V_BACK_480P};
            MODE_VGA:
                v_timing_n = {V_ACTIVE_VGA, V_FRONT_VGA, V_SYNC_VGA, V_BACK_VGA};
            MODE_576P:
                v_timing_n = {V_ACTIVE_576P, V_FRONT_576P, V_SYNC_576P, V_BACK_576P};
            MODE_240P_1080P, MODE_240P_960P, MODE_240P_480P, MODE_240P_VGA:
                v_timing_n = {V_ACTIVE_240P, V_FRONT_240P, V_SYNC_240P, V_BACK_240P};
            MODE_480I:
                v_timing_n = {V_ACTIVE_480I, V_FRONT_480I, V_SYNC_480I, V_BACK_480I};
            MODE_576I:
                v_timing_n = {V_ACTIVE_576I, V_FRONT_576I, V_SYNC_576I, V_BACK_576I};
            default:
                v_timing_n = {V_ACTIVE_1080P, V_FRONT_1080P, V_SYNC_1080P, V_BACK_1080P};
        endcase
    end

    always_ff @(posedge clock) begin
        {h_active, h_front, h_sync, h_back} <= h_timing_n;
        {v_active, v_front, v_sync, v_back} <= v_timing_n;
        interlaced <= (lookup_mode == MODE_480I) || (lookup_mode == MODE_576I);
    end

endmodule

//--- video_timing_gen.sv
`timescale 1ns/1ps

module video_timing_gen
    import video_timing_pkg::*;
(
    input  logic     clock,
    input  logic     rst_n,
    input  h_count_t h_active,
    input  h_count_t h_front,
    input  h_count_t h_sync,
    input  h_count_t h_back,
    input  v_count_t v_active,
    input  v_count_t v_front,
    input  v_count_t v_sync,
    input  v_count_t v_back,
    input  logic     interlaced,
    output logic     hsync,
    output logic     vsync,
    output logic     de,
    output logic     frame_start,
    output logic     field,
    output h_count_t h_pos,
    output v_count_t v_pos
);

    // Working copy of the timing, stable for a whole frame.
    h_count_t h_active_q;
    h_count_t h_front_q;
    h_count_t h_sync_q;
    h_count_t h_back_q;
    v_count_t v_active_q;
    v_count_t v_front_q;
    v_count_t v_sync_q;
    v_count_t v_back_q;
    logic     interlaced_q;

    h_count_t hs_start;
    h_count_t hs_end;
    h_count_t h_total_m1;
    h_count_t h_next;
    v_count_t vs_start;
    v_count_t vs_end;
    v_count_t v_total_m1;
    v_count_t v_next;
    logic     h_last;
    logic     v_last;
    logic     frame_end;

    assign hs_start   = h_active_q + h_front_q;
    assign hs_end     = hs_start + h_sync_q;
    assign h_total_m1 = hs_end + h_back_q - 12'd1;
    assign vs_start   = v_active_q + v_front_q;
    assign vs_end     = vs_start + v_sync_q;
    assign v_total_m1 = vs_end + v_back_q - 11'd1;

    assign h_last    = (h_pos == h_total_m1);
    assign v_last    = (v_pos == v_total_m1);
    assign frame_end = h_last && v_last;

    assign h_next = h_last ? '0 : h_pos + 12'd1;
    assign v_next = h_last ? (v_last ? '0 : v_pos + 11'd1) : v_pos;

    always_ff @(posedge clock) begin
        if (!rst_n || frame_end) begin  // New timing only between frames.
            h_active_q   <= h_active;
            h_front_q    <= h_front;
            h_sync_q     <= h_sync;
            h_back_q     <= h_back;
            v_active_q   <= v_active;
            v_front_q    <= v_front;
            v_sync_q     <= v_sync;
            v_back_q     <= v_back;
            interlaced_q <= interlaced;
        end
    end

    // Outputs decode the next position, so they line up with h_pos and v_pos.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            h_pos       <= '0;
            v_pos       <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            de          <= 1'b0;
            frame_start <= 1'b0;
            field       <= 1'b0;
        end else begin
            h_pos       <= h_next;
            v_pos       <= v_next;
            de          <= (h_next < h_active_q) && (v_next < v_active_q);
            hsync       <= (h_next >= hs_start) && (h_next < hs_end);
            vsync       <= (v_next >= vs_start) && (v_next < vs_end);
            frame_start <= frame_end;
            if (frame_end) begin
                field <= interlaced ? ~field : 1'b0;   // Follows the frame about to start.
            end
        end
    end

endmodule

//--- video_reconfig_top.sv
`timescale 1ns/1ps

module video_reconfig_top
    import video_mode_pkg::*;
    import video_timing_pkg::*;
(
    input  logic        clock,
    input  logic        rst_n,
    input  ctrl_byte_t  ctrl,
    output video_mode_t mode,
    output logic        native_hd,
    output logic        hsync,
    output logic        vsync,
    output logic        de,
    output logic        frame_start,
    output logic        field,
    output h_count_t    h_pos,
    output v_count_t    v_pos
);

    h_count_t h_active;
    h_count_t h_front;
    h_count_t h_sync;
    h_count_t h_back;
    v_count_t v_active;
    v_count_t v_front;
    v_count_t v_sync;
    v_count_t v_back;
    logic     interlaced;

    video_mode_select u_select (
        .clock     (clock),
        .rst_n     (rst_n),
        .ctrl      (ctrl),
        .mode      (mode),
        .native_hd (native_hd)
    );

    video_mode_table u_table (
        .clock      (clock),
        .rst_n      (rst_n),
        .mode       (mode),
        .h_active   (h_active),
        .h_front    (h_front),
        .h_sync     (h_sync),
        .h_back     (h_back),
        .v_active   (v_active),
        .v_front    (v_front),
        .v_sync     (v_sync),
        .v_back     (v_back),
        .interlaced (interlaced)
    );

    video_timing_gen u_timing (
        .clock       (clock),
        .rst_n       (rst_n),
        .h_active    (h_active),
        .h_front     (h_front),
        .h_sync      (h_sync),
        .h_back      (h_back),
        .v_active    (v_active),
        .v_front     (v_front),
        .v_sync      (v_sync),
        .v_back      (v_back),
        .interlaced  (interlaced),
        .hsync       (hsync),
        .vsync       (vsync),
        .de          (de),
        .frame_start (frame_start),
        .field       (field),
        .h_pos       (h_pos),
        .v_pos       (v_pos)
    );

endmodule

//--- video_reconfig_checker.sv
`timescale 1ns/1ps

module video_reconfig_checker (
    input logic clock,
    input logic rst_n,
    input logic hsync,
    input logic de,
    input logic frame_start,
    input logic field,
    input logic interlaced
);

    int fail_count = 0;

    assert property (@(posedge clock) disable iff (!rst_n) frame_start |=> !frame_start)
        else begin
            $error("frame_start high for more than one cycle");
            fail_count++;
        end

    assert property (@(posedge clock) disable iff (!rst_n) !(de && hsync))
        else begin
            $error("de high during hsync");
            fail_count++;
        end

    // Working copy, so a mid-frame mode change does not count.
    assert property (@(posedge clock) disable iff (!rst_n) !interlaced |-> !field)
        else begin
            $error("field set in a progressive frame");
            fail_count++;
        end

endmodule

bind video_timing_gen video_reconfig_checker u_checker (
    .clock       (clock),
    .rst_n       (rst_n),
    .hsync       (hsync),
    .de          (de),
    .frame_start (frame_start),
    .field       (field),
    .interlaced  (interlaced_q)
);

//--- tb_video_reconfig.sv
`timescale 1ns/1ps

module tb_video_reconfig
    import video_mode_pkg::*;
    import video_timing_pkg::*;
();

    localparam int LINE_TIMEOUT  = 5000;
    localparam int FRAME_TIMEOUT = 3000000;    // Longer than one 1080p frame.

    logic        clock = 1'b0;
    logic        rst_n;
    ctrl_byte_t  ctrl;
    video_mode_t mode;
    logic        native_hd, hsync, vsync, de, frame_start, field;
    h_count_t    h_pos;
    v_count_t    v_pos;

    video_mode_t model_mode;    // Expected selection.
    ctrl_byte_t  model_ctrl;    // Byte the selector holds.
    int          errors = 0;
    integer      seed = 32'h0d95_e3bf;

    always #2 clock = ~clock;

    video_reconfig_top dut0 (
        .clock(clock), .rst_n(rst_n), .ctrl(ctrl), .mode(mode), .native_hd(native_hd),
        .hsync(hsync), .vsync(vsync), .de(de), .frame_start(frame_start), .field(field),
        .h_pos(h_pos), .v_pos(v_pos)
    );

    function automatic video_mode_t rule_mode(input logic [6:0] code, input video_mode_t prev);
        case (code)
            7'h00: return MODE_1080P;
            7'h01: return MODE_960P;
            7'h02: return MODE_480P;
            7'h03: return MODE_VGA;
            7'h08, 7'h09, 7'h0a, 7'h0b: return MODE_576P;
            7'h10: return MODE_240P_1080P;
            7'h11: return MODE_240P_960P;
            7'h12: return MODE_240P_480P;
            7'h13: return MODE_240P_VGA;
            7'h20, 7'h21, 7'h22, 7'h23: return MODE_480I;
            7'h40, 7'h41, 7'h42, 7'h43: return MODE_576I;
            default: return prev;
        endcase
    endfunction

    // An unlisted code returns whatever mode it is given.
    function automatic logic is_listed(input logic [6:0] code);
        return rule_mode(code, MODE_480I) == rule_mode(code, MODE_576I);
    endfunction

    function automatic int line_length(input h_count_t act, input h_count_t fp,
                                       input h_count_t sw, input h_count_t bp);
        return int'(act) + int'(fp) + int'(sw) + int'(bp);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_mode(input video_mode_t exp);
        check_value("mode", 32'(mode), 32'(exp));
        check_value("native_hd", 32'(native_hd), 32'(exp == MODE_1080P || exp == MODE_960P));
    endtask

    task automatic apply_code(input ctrl_byte_t value);
        video_mode_t old_mode;
        old_mode = model_mode;
        if (value != model_ctrl) begin
            model_mode = rule_mode(value[6:0], model_mode);
        end
        model_ctrl = value;
        ctrl = value;
        @(negedge clock);
        check_mode(old_mode);   // Decode stage only.
        @(negedge clock);
        check_mode(model_mode);
    endtask

    task automatic hold_ctrl(input int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_mode(model_mode);
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!frame_start && n < FRAME_TIMEOUT);
        if (!frame_start) begin
            $display("timeout waiting for frame start");
            errors++;
        end
    endtask

    // Counts cycles, de cycles and hsync cycles up to the next hsync rise.
    task automatic wait_hsync_rise(output int cycles, output int de_cycles, output int hs_cycles);
        logic last;
        logic rise;
        cycles = 0;
        de_cycles = 0;
        hs_cycles = 0;
        rise = 1'b0;
        last = hsync;
        while (!rise && cycles < LINE_TIMEOUT) begin
            if (de) de_cycles++;
            if (hsync) hs_cycles++;
            @(negedge clock);
            cycles++;
            rise = hsync && !last;
            last = hsync;
        end
        if (!rise) begin
            $display("timeout waiting for hsync rise");
            errors++;
        end
    endtask

    task automatic check_line(input h_count_t act, input h_count_t fp,
                              input h_count_t sw, input h_count_t bp);
        int total;
        int de_cycles;
        int hs_cycles;
        wait_hsync_rise(total, de_cycles, hs_cycles);
        wait_hsync_rise(total, de_cycles, hs_cycles);
        check_value("line_total", total, line_length(act, fp, sw, bp));
        check_value("de_cycles", de_cycles, int'(act));
        check_value("hsync_cycles", hs_cycles, int'(sw));
        check_value("h_pos", 32'(h_pos), int'(act) + int'(fp));
    endtask

    task automatic scan_frame(input int de_len, input int vs_line,
                              output int lines, output int vs_cycles);
        int   run;
        int   n;
        logic vs_last;
        run = 0;
        lines = 0;
        vs_cycles = 0;
        vs_last = vsync;
        n = 0;
        do begin
            if (de) begin
                run++;
            end else if (run != 0) begin
                check_value("de_run", run, de_len);
                lines++;
                run = 0;
            end
            if (vsync) begin
                vs_cycles++;
            end
            @(negedge clock);
            n++;
            if (vsync && !vs_last) begin    // Vsync opens at the start of a line.
                check_value("v_pos", 32'(v_pos), vs_line);
                check_value("h_pos", 32'(h_pos), 32'h0);
            end
            vs_last = vsync;
        end while (!frame_start && n < FRAME_TIMEOUT);
        if (frame_start) begin
            check_value("h_pos", 32'(h_pos), 32'h0);
            check_value("v_pos", 32'(v_pos), 32'h0);
        end else begin
            $display("timeout waiting for frame start");
            errors++;
        end
    endtask

    task automatic reset_state();
        check_mode(MODE_1080P);
        check_value("h_pos", 32'(h_pos), 32'h0);
        check_value("v_pos", 32'(v_pos), 32'h0);
        check_value("hsync", 32'(hsync), 32'h0);
        check_value("vsync", 32'(vsync), 32'h0);
        check_value("de", 32'(de), 32'h0);
        check_value("frame_start", 32'(frame_start), 32'h0);
        check_value("field", 32'(field), 32'h0);
        check_line(H_ACTIVE_1080P, H_FRONT_1080P, H_SYNC_1080P, H_BACK_1080P);
    endtask

    task automatic decode_table();
        ctrl_byte_t codes[9] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h09, 8'h11, 8'h13, 8'h22, 8'h41};
        foreach (codes[i]) begin
            apply_code(codes[i]);
        end
    endtask

    task automatic change_detection();
        apply_code(8'h00);
        apply_code(8'h80);      // Same mode code, new byte.
        hold_ctrl(8);
        apply_code(8'h83);      // Bit 7 set on a new mode.
        apply_code(8'h03);
        apply_code(8'h0a);
        apply_code(8'h0b);      // Alias of 576p.
        hold_ctrl(8);
    endtask

    task automatic unlisted_codes();
        logic [31:0] rnd;
        ctrl_byte_t  value;
        apply_code(8'h02);
        repeat (8) begin
            do begin
                rnd = $random(seed);
                value = rnd[7:0];
            end while (is_listed(value[6:0]));
            apply_code(value);
        end
    endtask

    task automatic frame_reload();
        int lines;
        int vs_cycles;
        int total_1080p;
        int total_vga;
        total_1080p = line_length(H_ACTIVE_1080P, H_FRONT_1080P, H_SYNC_1080P, H_BACK_1080P);
        total_vga = line_length(H_ACTIVE_VGA, H_FRONT_VGA, H_SYNC_VGA, H_BACK_VGA);
        apply_code(8'h00);
        wait_frame_start();
        check_line(H_ACTIVE_1080P, H_FRONT_1080P, H_SYNC_1080P, H_BACK_1080P);
        apply_code(8'h03);      // Now on line 1 of a 1080p frame.
        scan_frame(int'(H_ACTIVE_1080P), int'(V_ACTIVE_1080P) + int'(V_FRONT_1080P),
                   lines, vs_cycles);
        check_value("de_lines", lines, int'(V_ACTIVE_1080P) - 2);
        check_value("vsync_cycles", vs_cycles, int'(V_SYNC_1080P) * total_1080p);
        scan_frame(int'(H_ACTIVE_VGA), int'(V_ACTIVE_VGA) + int'(V_FRONT_VGA),
                   lines, vs_cycles);
        check_value("de_lines", lines, int'(V_ACTIVE_VGA));
        check_value("vsync_cycles", vs_cycles, int'(V_SYNC_VGA) * total_vga);
        check_line(H_ACTIVE_VGA, H_FRONT_VGA, H_SYNC_VGA, H_BACK_VGA);
    endtask

    task automatic interlace_field();
        logic exp_field;
        exp_field = 1'b0;       // Field is low in VGA.
        apply_code(8'h20);
        repeat (3) begin
            wait_frame_start();
            exp_field = !exp_field;
            check_value("field", 32'(field), 32'(exp_field));
        end
        apply_code(8'h02);
        repeat (2) begin
            wait_frame_start();
            check_value("field", 32'(field), 32'h0);
        end
    endtask

    initial begin
        int asserts;
        rst_n = 1'b0;
        ctrl = 8'h00;
        model_mode = MODE_1080P;
        model_ctrl = 8'h00;
        repeat (5) @(negedge clock);
        rst_n = 1'b1;
        reset_state();
        decode_table();
        change_detection();
        unlisted_codes();
        frame_reload();
        interlace_field();
        asserts = dut0.u_timing.u_checker.fail_count;
        $display("Errors: %0d in checks, %0d in assertions", errors, asserts);
        if (errors == 0 && asserts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- flist.f
video_timing_pkg.sv
video_mode_pkg.sv
video_mode_select.sv
video_mode_table.sv
video_timing_gen.sv
video_reconfig_top.sv
video_reconfig_checker.sv
tb_video_reconfig.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  = +verilator+error+limit+100
TOP       = tb_video_reconfig
FLIST     = flist.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
